// ==== logic/ebusPkg.sv ====
package ebusPkg;

  // width of one EBUS data word, bit 0 is the most significant
  localparam int unsigned ebusWidth = 36;

  // the datapath is split over this many boards
  localparam int unsigned numSlices = 6;

  // bits owned by each datapath board
  localparam int unsigned sliceWidth = 6;

  // KL10 numbering, 0 on the left and 35 on the right
  typedef logic [0:ebusWidth-1] ebusWordT;

  typedef logic [0:sliceWidth-1] ebusSliceT;

  // controller select, cut down from the seven-bit cs field
  typedef enum logic [2:0]
  {
    csNone  = 3'd0,
    csEdp   = 3'd1,
    csMeter = 3'd2
  } ebusCsT;

  // diagnostic function code
  typedef enum logic
  {
    dsRead  = 1'b0,
    dsWrite = 1'b1
  } ebusDsT;

  // one diagnostic command moving down the pipeline
  typedef struct packed
  {
    logic     valid;
    ebusCsT   cs;
    ebusDsT   ds;
    ebusWordT data;
  } ebusCmdT;

  // what a single board puts on the EBUS data lines
  typedef struct packed
  {
    logic     driving;
    ebusWordT data;
  } ebusDriverT;

endpackage

// ==== logic/diagDecode.sv ====
`timescale 1ns/1ps

module diagDecode
(
  input  logic                clk,
  input  logic                reset,
  input  logic                diagStrobe,
  input  ebusPkg::ebusCsT     cs,
  input  ebusPkg::ebusDsT     ds,
  input  ebusPkg::ebusWordT   wrData,
  output ebusPkg::ebusCmdT    stageCmd,
  output ebusPkg::ebusDriverT feDriver
);

  import ebusPkg::*;

  ebusCsT   decodedCs;
  ebusWordT cmdData;

  // any select this design does not know about addresses no board
  always_comb
  begin
    case (cs)
      csEdp:   decodedCs = csEdp;
      csMeter: decodedCs = csMeter;
      default: decodedCs = csNone;
    endcase
  end

  // a read carries no data, so an old write word cannot leak onto the bus
  always_comb
  begin
    if (ds == dsWrite)
      cmdData = wrData;
    else
      cmdData = '0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stageCmd <= '0;
    end
    else
    begin
      stageCmd.valid <= diagStrobe;
      stageCmd.cs    <= decodedCs;
      stageCmd.ds    <= ds;
      stageCmd.data  <= cmdData;
    end
  end

  // the front end drives the EBUS itself while a write is in the board stage
  always_comb
  begin
    feDriver.driving = stageCmd.valid && (stageCmd.ds == dsWrite);
    feDriver.data    = stageCmd.data;
  end

endmodule

// ==== logic/edpSlice.sv ====
`timescale 1ns/1ps

module edpSlice
#(
  parameter int unsigned sliceIndex = 0
)
(
  input  logic                clk,
  input  logic                reset,
  input  ebusPkg::ebusCmdT    stageCmd,
  input  ebusPkg::ebusWordT   ebusData,
  output ebusPkg::ebusDriverT driver
);

  import ebusPkg::*;

  // leftmost bit of the field this board owns
  localparam int unsigned fieldLo = sliceIndex * sliceWidth;

  ebusSliceT sliceReg;
  logic      edpSelected;
  logic      edpWrite;
  logic      edpRead;

  always_comb
  begin
    edpSelected = stageCmd.valid && (stageCmd.cs == csEdp);
    edpWrite    = edpSelected && (stageCmd.ds == dsWrite);
    edpRead     = edpSelected && (stageCmd.ds == dsRead);
  end

  // the write lands at the end of the board stage, so a read
  // on the very next cycle already sees it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sliceReg <= '0;
    end
    else if (edpWrite)
    begin
      sliceReg <= ebusData[fieldLo +: sliceWidth];
    end
  end

  always_comb
  begin
    driver.driving = edpRead;
    driver.data    = '0;
    driver.data[fieldLo +: sliceWidth] = sliceReg;
  end

endmodule

// ==== logic/meterBoard.sv ====
`timescale 1ns/1ps

module meterBoard
#(
  parameter int unsigned countWidth = 16
)
(
  input  logic                clk,
  input  logic                reset,
  input  ebusPkg::ebusCmdT    stageCmd,
  input  ebusPkg::ebusWordT   ebusData,
  output ebusPkg::ebusDriverT driver
);

  import ebusPkg::*;

  // the count sits right-justified, ending at bit 35
  localparam int unsigned countLo = ebusWidth - countWidth;

  logic [countWidth-1:0] activityCount;
  logic                  meterSelected;
  logic                  meterWrite;
  logic                  meterRead;

  always_comb
  begin
    meterSelected = stageCmd.valid && (stageCmd.cs == csMeter);
    meterWrite    = meterSelected && (stageCmd.ds == dsWrite);
    meterRead     = meterSelected && (stageCmd.ds == dsRead);
  end

  // every command through the board stage bumps the count,
  // except a preset which replaces it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      activityCount <= '0;
    end
    else if (meterWrite)
    begin
      activityCount <= ebusData[countLo +: countWidth];
    end
    else if (stageCmd.valid)
    begin
      activityCount <= activityCount + 1'b1;
    end
  end

  // a read returns the count as it stood before this command
  always_comb
  begin
    driver.driving = meterRead;
    driver.data    = '0;
    driver.data[countLo +: countWidth] = activityCount;
  end

endmodule

// ==== logic/ebusMux.sv ====
`timescale 1ns/1ps

module ebusMux
(
  input  ebusPkg::ebusDriverT feDriver,
  input  ebusPkg::ebusDriverT sliceDrivers [ebusPkg::numSlices],
  input  ebusPkg::ebusDriverT meterDriver,
  output ebusPkg::ebusWordT   ebusData
);

  import ebusPkg::*;

  logic     anySliceDriving;
  ebusWordT sliceWord;

  always_comb
  begin
    anySliceDriving = 1'b0;
    for (int i = 0; i < numSlices; i++)
    begin
      anySliceDriving = anySliceDriving | sliceDrivers[i].driving;
    end
  end

  // each board only owns its own six bits, so the word is built
  // up field by field from the board behind each one
  always_comb
  begin
    sliceWord = '0;
    for (int i = 0; i < numSlices; i++)
    begin
      sliceWord[i * sliceWidth +: sliceWidth] =
        sliceDrivers[i].data[i * sliceWidth +: sliceWidth];
    end
  end

  // front end first, then the datapath, then the meter
  always_comb
  begin
    if (feDriver.driving)
    begin
      ebusData = feDriver.data;
    end
    else if (anySliceDriving)
    begin
      ebusData = sliceWord;
    end
    else if (meterDriver.driving)
    begin
      ebusData = meterDriver.data;
    end
    else
    begin
      // nobody on the bus reads as zero
      ebusData = '0;
    end
  end

endmodule

// ==== logic/feCapture.sv ====
`timescale 1ns/1ps

module feCapture
(
  input  logic              clk,
  input  logic              reset,
  input  ebusPkg::ebusCmdT  stageCmd,
  input  ebusPkg::ebusWordT ebusData,
  output logic              rspValid,
  output ebusPkg::ebusWordT rspData
);

  import ebusPkg::*;

  logic readInStage;

  always_comb
  begin
    readInStage = stageCmd.valid && (stageCmd.ds == dsRead);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rspValid <= 1'b0;
    else
      rspValid <= readInStage;
  end

  // the response word stays put until the next read comes through
  always_ff @(posedge clk)
  begin
    if (readInStage)
      rspData <= ebusData;
  end

endmodule

// ==== logic/klEbusTop.sv ====
`timescale 1ns/1ps

module klEbusTop
#(
  parameter int unsigned meterCountWidth = 16
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              diagStrobe,
  input  ebusPkg::ebusCsT   cs,
  input  ebusPkg::ebusDsT   ds,
  input  ebusPkg::ebusWordT wrData,
  output logic              rspValid,
  output ebusPkg::ebusWordT rspData
);

  import ebusPkg::*;

  ebusCmdT    stageCmd;
  ebusDriverT feDriver;
  ebusDriverT sliceDrivers [numSlices];
  ebusDriverT meterDriver;
  ebusWordT   ebusData;

  diagDecode u_diagDecode
  (
    .clk        (clk),
    .reset      (reset),
    .diagStrobe (diagStrobe),
    .cs         (cs),
    .ds         (ds),
    .wrData     (wrData),
    .stageCmd   (stageCmd),
    .feDriver   (feDriver)
  );

  // six datapath boards, one per 6-bit field of the word
  for (genvar i = 0; i < numSlices; i++)
  begin : gSlice
    edpSlice
    #(
      .sliceIndex (i)
    )
    u_edpSlice
    (
      .clk      (clk),
      .reset    (reset),
      .stageCmd (stageCmd),
      .ebusData (ebusData),
      .driver   (sliceDrivers[i])
    );
  end

  meterBoard
  #(
    .countWidth (meterCountWidth)
  )
  u_meterBoard
  (
    .clk      (clk),
    .reset    (reset),
    .stageCmd (stageCmd),
    .ebusData (ebusData),
    .driver   (meterDriver)
  );

  ebusMux u_ebusMux
  (
    .feDriver     (feDriver),
    .sliceDrivers (sliceDrivers),
    .meterDriver  (meterDriver),
    .ebusData     (ebusData)
  );

  feCapture u_feCapture
  (
    .clk      (clk),
    .reset    (reset),
    .stageCmd (stageCmd),
    .ebusData (ebusData),
    .rspValid (rspValid),
    .rspData  (rspData)
  );

endmodule

// ==== test/tbKlEbus.sv ====
`timescale 1ns/1ps

module tbKlEbus;

  import ebusPkg::*;

  localparam int unsigned meterBits = 16;
  localparam int drainCycles = 20;

  logic     clk;
  logic     reset;
  logic     diagStrobe;
  ebusCsT   cs;
  ebusDsT   ds;
  ebusWordT wrData;
  logic     rspValid;
  ebusWordT rspData;

  integer seed = 67506;

  // reference model state
  logic [0:sliceWidth-1] modelSlices [numSlices];
  logic [meterBits-1:0]  modelCount;
  ebusWordT              expQ [$];
  string                 nameQ [$];

  // reads seen on the inputs, shifted along to line up with rspValid
  logic [1:0] readPending;

  klEbusTop
  #(
    .meterCountWidth (meterBits)
  )
  u_klEbusTop
  (
    .clk        (clk),
    .reset      (reset),
    .diagStrobe (diagStrobe),
    .cs         (cs),
    .ds         (ds),
    .wrData     (wrData),
    .rspValid   (rspValid),
    .rspData    (rspData)
  );

  always #5 clk = ~clk;

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic ebusWordT randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[3:0], lo};
  endfunction

  // the model sees each command in issue order, just as the board stage does
  task automatic applyModel(input ebusCsT c, input ebusDsT d, input ebusWordT w,
                            input string name);
    ebusWordT expWord;
    expWord = '0;
    if (d == dsRead)
    begin
      if (c == csEdp)
      begin
        for (int i = 0; i < numSlices; i++)
          expWord[i * sliceWidth +: sliceWidth] = modelSlices[i];
      end
      else if (c == csMeter)
      begin
        expWord = {20'd0, modelCount};
      end
      expQ.push_back(expWord);
      nameQ.push_back(name);
    end
    if (c == csEdp && d == dsWrite)
    begin
      for (int i = 0; i < numSlices; i++)
        modelSlices[i] = w[i * sliceWidth +: sliceWidth];
    end
    if (c == csMeter && d == dsWrite)
      modelCount = w[20:35];
    else
      modelCount = modelCount + 1'b1;
  endtask

  task automatic issueCmd(input ebusCsT c, input ebusDsT d, input ebusWordT w,
                          input string name);
    @(negedge clk);
    diagStrobe = 1'b1;
    cs         = c;
    ds         = d;
    wrData     = w;
    applyModel(c, d, w, name);
  endtask

  task automatic idleBus();
    @(negedge clk);
    diagStrobe = 1'b0;
    cs         = csNone;
    ds         = dsRead;
    wrData     = '0;
  endtask

  task automatic waitForResponses();
    int waited;
    waited = 0;
    while (expQ.size() != 0)
    begin
      if (waited >= drainCycles)
      begin
        stopOnError($sformatf("timed out with %0d read responses still missing",
                              expQ.size()));
      end
      else
      begin
        @(posedge clk);
        waited++;
      end
    end
  endtask

  // outputs are read at the rising edge before the registers update
  always @(posedge clk)
  begin
    if (reset)
    begin
      readPending <= 2'b00;
    end
    else
    begin
      readPending <= {readPending[0], diagStrobe && (ds == dsRead)};
      assert (rspValid == readPending[1])
      else
        stopOnError($sformatf("rspValid was %b but a response %s expected",
                              rspValid, readPending[1] ? "was" : "was not"));
      if (rspValid)
      begin
        assert (expQ.size() > 0)
        else
          stopOnError("a read response arrived with nothing left to compare it to");
        assert (rspData == expQ[0])
        else
          stopOnError($sformatf("FAIL %s expected %h actual %h",
                                nameQ[0], expQ[0], rspData));
        expQ.pop_front();
        nameQ.pop_front();
      end
    end
  end

  initial
  begin
    ebusWordT w;
    logic [31:0] pick;
    clk        = 1'b0;
    reset      = 1'b1;
    diagStrobe = 1'b0;
    cs         = csNone;
    ds         = dsRead;
    wrData     = '0;
    modelCount = '0;
    for (int i = 0; i < numSlices; i++)
      modelSlices[i] = '0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // nothing issued, so rspValid has to stay low
    repeat (5) @(negedge clk);
    issueCmd(csMeter, dsRead, '0, "resetMeter");
    issueCmd(csEdp, dsRead, '0, "resetEdp");
    idleBus();
    waitForResponses();

    for (int n = 0; n < 4; n++)
    begin
      w = randomWord();
      issueCmd(csEdp, dsWrite, w, "edpReadback");
      idleBus();
      issueCmd(csEdp, dsRead, '0, "edpReadback");
      idleBus();
      waitForResponses();
    end

    issueCmd(csEdp, dsWrite, randomWord(), "backToBack");
    issueCmd(csEdp, dsRead, '0, "backToBack");
    issueCmd(csMeter, dsWrite, randomWord(), "backToBack");
    issueCmd(csMeter, dsRead, '0, "backToBack");
    for (int n = 0; n < 24; n++)
    begin
      pick = $random(seed);
      issueCmd((pick[1:0] == 2'd0) ? csNone : (pick[1:0] == 2'd1) ? csMeter : csEdp,
               pick[2] ? dsWrite : dsRead, randomWord(), "backToBack");
    end
    idleBus();
    waitForResponses();

    issueCmd(csMeter, dsWrite, randomWord(), "meterCount");
    issueCmd(csMeter, dsRead, '0, "meterCount");
    for (int n = 0; n < 5; n++)
      issueCmd(csNone, dsWrite, randomWord(), "meterCount");
    idleBus();
    issueCmd(csMeter, dsRead, '0, "meterCount");
    idleBus();
    waitForResponses();

    issueCmd(csNone, dsRead, '0, "unaddressed");
    issueCmd(csNone, dsWrite, randomWord(), "unaddressed");
    issueCmd(csEdp, dsRead, '0, "unaddressed");
    issueCmd(csMeter, dsRead, '0, "unaddressed");
    idleBus();
    waitForResponses();

    repeat (4) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== klEbus.f ====
logic/ebusPkg.sv
logic/diagDecode.sv
logic/edpSlice.sv
logic/meterBoard.sv
logic/ebusMux.sv
logic/feCapture.sv
logic/klEbusTop.sv
test/tbKlEbus.sv

// ==== Bender.yml ====
package:
  name: klEbus

dependencies: {}

sources:
  # package first, then the stages, then the top level
  - logic/ebusPkg.sv
  - logic/diagDecode.sv
  - logic/edpSlice.sv
  - logic/meterBoard.sv
  - logic/ebusMux.sv
  - logic/feCapture.sv
  - logic/klEbusTop.sv

  - target: test
    files:
      - test/tbKlEbus.sv
